//--- synthCore.f
+incdir+.
synthPkg.sv
voiceCtrlIf.sv
noteDispatcher.sv
oscVoice.sv
voiceMixer.sv
synthCore.sv
tbSynthCore.sv

//--- Bender.yml
package:
  name: synthCore

export_include_dirs:
  - .

sources:
  # Design, in compile order
  - include_dirs:
      - .
    files:
      - synthPkg.sv
      - voiceCtrlIf.sv
      - noteDispatcher.sv
      - oscVoice.sv
      - voiceMixer.sv
      - synthCore.sv

  # Testbench
  - target: test
    include_dirs:
      - .
    files:
      - tbSynthCore.sv

//--- tbSynthCore.sv
`include "synth_settings.svh"

module tbSynthCore;
	import synthPkg::*;

	// Five tests of at most 400 cycles, plus reset margin
	localparam int CYCLE_LIMIT = 5 * 400 + 200;
	// Lone full scale square at the reset level
	localparam int SQ_HI = (32767 * `LEVEL_RESET) >>> `MIX_SHIFT;
	localparam int SQ_LO = (-32768 * `LEVEL_RESET) >>> `MIX_SHIFT;

	logic                      MAX10_CLK2_50;
	logic                      arstN;
	logic                      cmdValid;
	logic [11:0]               cmdWord;
	logic                      sampleTick;
	logic signed [`SAMP_W-1:0] sampleOut;
	logic                      sampleValid;

	// Reference model state, one entry per voice
	logic [`PHASE_W-1:0]       mPhase [`NUM_VOICES];
	logic [`PHASE_W-1:0]       mInc [`NUM_VOICES];
	logic                      mGate [`NUM_VOICES];
	waveSel                    mWave [`NUM_VOICES];
	int                        mLevel;
	logic signed [`SAMP_W-1:0] expOut;
	logic signed [`SAMP_W-1:0] lastSample;

	string testName;
	bit    squareOnly;
	int    errCount;
	int    testCount;
	int    cleanCount;
	int    testErrStart;
	int    seed;
	int    cycleCount;
	int    lowNote;
	int    loCount;
	int    hiCount;

	synthCore i_dut (
		.MAX10_CLK2_50 (MAX10_CLK2_50),
		.arstN         (arstN),
		.cmdValid      (cmdValid),
		.cmdWord       (cmdWord),
		.sampleTick    (sampleTick),
		.sampleOut     (sampleOut),
		.sampleValid   (sampleValid)
	);

	initial begin
		MAX10_CLK2_50 = 1'b0;
		forever #5 MAX10_CLK2_50 = ~MAX10_CLK2_50;
	end

	// ====================
	// Pitch and wave rules
	// ====================

	// Lowest octave entry, one doubling per octave
	function automatic logic [`PHASE_W-1:0] incFor(int note);
		return semitoneInc[note % 12] << (note / 12);
	endfunction

	function automatic int shapeOf(logic gate, waveSel wave, logic [`PHASE_W-1:0] ph);
		int top;
		int fold;
		top = ph[`PHASE_W-1 -: `SAMP_W];
		fold = (top < 32768) ? top : 65535 - top;
		if (!gate) return 0;
		case (wave)
			waveSaw: return (top < 32768) ? top : top - 65536;
			waveSquare: return (top < 32768) ? 32767 : -32768;
			// Rises over the first half, falls over the second
			waveTri: return 2 * fold - 32768;
			default: return 0;
		endcase
	endfunction

	function automatic int randNote(int maxNote);
		return ($random(seed) & 32'h7fffffff) % (maxNote + 1);
	endfunction

	// ====================
	// Stimulus tasks
	// ====================

	// One sample tick, model advanced in step
	task automatic tickOnce();
		int sum;
		int waitCnt;
		sum = 0;
		waitCnt = 0;
		@(negedge MAX10_CLK2_50);
		for (int v = 0; v < `NUM_VOICES; v++) begin
			mPhase[v] = mPhase[v] + mInc[v];
			sum += shapeOf(mGate[v], mWave[v], mPhase[v]);
		end
		expOut = `SAMP_W'((sum * mLevel) >>> `MIX_SHIFT);
		sampleTick = 1'b1;
		@(negedge MAX10_CLK2_50);
		sampleTick = 1'b0;
		do begin
			@(negedge MAX10_CLK2_50);
			waitCnt++;
		end while (!sampleValid && waitCnt < 4);
		if (!sampleValid) begin
			errCount++;
			$display("no sampleValid after sampleTick in %s", testName);
		end
		lastSample = sampleOut;
		@(negedge MAX10_CLK2_50);
	endtask

	task automatic runTicks(int n);
		repeat (n) tickOnce();
	endtask

	task automatic sendNote(int voice, bit gate, waveSel wave, int note);
		synthCmd c;
		c = '0;
		c.asNote.kind = 1'b0;
		c.asNote.voice = 2'(voice);
		c.asNote.gate = gate;
		c.asNote.wave = wave;
		c.asNote.noteIdx = `NOTE_W'(note);
		// Indexes above 30 leave the voice as it was
		if (note <= 30) begin
			mGate[voice] = gate;
			mWave[voice] = wave;
			mInc[voice] = incFor(note);
			if (gate) mPhase[voice] = '0;
		end
		@(negedge MAX10_CLK2_50);
		cmdWord = c;
		cmdValid = 1'b1;
		@(negedge MAX10_CLK2_50);
		cmdValid = 1'b0;
	endtask

	task automatic sendLevel(int level);
		synthCmd c;
		c = '0;
		c.asLevel.kind = 1'b1;
		c.asLevel.level = `LEVEL_W'(level);
		mLevel = level;
		@(negedge MAX10_CLK2_50);
		cmdWord = c;
		cmdValid = 1'b1;
		@(negedge MAX10_CLK2_50);
		cmdValid = 1'b0;
	endtask

	// Ticks of positive output right after a square note-on
	task automatic halfPeriod(int note, output int count);
		count = 0;
		sendNote(0, 1'b1, waveSquare, note);
		tickOnce();
		while (lastSample > 0 && count < 24) begin
			count++;
			tickOnce();
		end
	endtask

	task automatic checkPositive();
		tickOnce();
		assert (lastSample > 0) else begin
			errCount++;
			$display("mismatch %s expected above 0 actual %0d", testName, lastSample);
		end
	endtask

	task automatic startTest(string name);
		testName = name;
		testErrStart = errCount;
		testCount++;
	endtask

	task automatic endTest();
		if (errCount == testErrStart) begin
			cleanCount++;
			$display("test %s: ok", testName);
		end else begin
			$display("test %s: %0d errors", testName, errCount - testErrStart);
		end
	endtask

	// ====================
	// Output checks
	// ====================

	// Every output sample against the model
	assert property (@(posedge MAX10_CLK2_50) disable iff (!arstN)
		sampleValid |-> (sampleOut == expOut))
	else begin
		errCount++;
		$display("mismatch %s expected %0d actual %0d", testName, $sampled(expOut),
			$sampled(sampleOut));
	end

	// Lone square only swings between the two rails
	assert property (@(posedge MAX10_CLK2_50) disable iff (!arstN)
		(sampleValid && squareOnly) |-> (sampleOut == SQ_HI || sampleOut == SQ_LO))
	else begin
		errCount++;
		$display("mismatch %s expected %0d or %0d actual %0d", testName, SQ_HI, SQ_LO,
			$sampled(sampleOut));
	end

	// Fixed two cycle latency, both directions
	assert property (@(posedge MAX10_CLK2_50) disable iff (!arstN)
		sampleTick |-> ##2 sampleValid)
	else begin
		errCount++;
		$display("sampleValid missing two cycles after sampleTick in %s", testName);
	end

	assert property (@(posedge MAX10_CLK2_50) disable iff (!arstN)
		sampleValid |-> $past(sampleTick, 2))
	else begin
		errCount++;
		$display("sampleValid without a sampleTick two cycles before in %s", testName);
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < CYCLE_LIMIT) begin
			@(posedge MAX10_CLK2_50);
			cycleCount++;
		end
		$display("timeout after %0d cycles in %s", cycleCount, testName);
		$display("tests failed");
		$finish;
	end

	// ====================
	// Test sequence
	// ====================
	initial begin
		arstN = 1'b0;
		cmdValid = 1'b0;
		cmdWord = '0;
		sampleTick = 1'b0;
		seed = 54703;
		errCount = 0;
		testCount = 0;
		cleanCount = 0;
		squareOnly = 1'b0;
		testName = "reset";
		mLevel = `LEVEL_RESET;
		expOut = '0;
		lastSample = '0;
		for (int v = 0; v < `NUM_VOICES; v++) begin
			mPhase[v] = '0;
			mInc[v] = '0;
			mGate[v] = 1'b0;
			mWave[v] = waveOff;
		end
		repeat (4) @(negedge MAX10_CLK2_50);
		arstN = 1'b1;

		// Silent output with all gates off
		startTest("reset");
		assert (sampleValid === 1'b0) else begin
			errCount++;
			$display("sampleValid high right after reset");
		end
		runTicks(16);
		endTest();

		startTest("square");
		sendNote(0, 1'b1, waveSquare, randNote(30));
		squareOnly = 1'b1;
		checkPositive();
		checkPositive();
		runTicks(30);
		squareOnly = 1'b0;
		endTest();

		startTest("sawTri");
		sendNote(0, 1'b0, waveOff, 0);
		sendNote(1, 1'b1, waveSaw, randNote(30));
		sendNote(2, 1'b1, waveTri, randNote(30));
		runTicks(20);
		// Out of range note, voice 3 stays silent
		sendNote(3, 1'b1, waveSquare, 31);
		runTicks(10);
		sendNote(1, 1'b1, waveTri, randNote(30));
		sendNote(2, 1'b1, waveSaw, randNote(30));
		runTicks(20);
		endTest();

		startTest("levelGate");
		sendNote(3, 1'b1, waveSquare, randNote(30));
		runTicks(8);
		sendLevel(200);
		runTicks(12);
		// Voice 1 drops out of the sum
		sendNote(1, 1'b0, waveSaw, 0);
		runTicks(12);
		sendLevel(7);
		runTicks(8);
		endTest();

		startTest("allVoices");
		sendLevel(255);
		for (int v = 0; v < `NUM_VOICES; v++) begin
			sendNote(v, 1'b1, waveSel'(v % 3), randNote(30));
		end
		runTicks(24);
		for (int v = 0; v < `NUM_VOICES; v++) begin
			sendNote(v, 1'b0, waveOff, 0);
		end
		// Octave up halves the square half period
		lowNote = randNote(18);
		halfPeriod(lowNote, loCount);
		halfPeriod(lowNote + 12, hiCount);
		assert (2 * hiCount >= loCount - 2 && 2 * hiCount <= loCount + 2) else begin
			errCount++;
			$display("mismatch %s expected %0d ticks actual %0d", testName, loCount / 2,
				hiCount);
		end
		endTest();

		$display("%0d of %0d tests clean, %0d errors", cleanCount, testCount, errCount);
		if (errCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- synthCore.sv
`include "synth_settings.svh"

module synthCore (
	input  logic                                    MAX10_CLK2_50,
	input  logic                                    arstN,
	input  logic                                    cmdValid,
	input  logic [$bits(synthPkg::synthCmd)-1:0]    cmdWord,
	input  logic                                    sampleTick,
	output logic signed [`SAMP_W-1:0]               sampleOut,
	output logic                                    sampleValid
);

	logic [`LEVEL_W-1:0]       masterLevel;
	logic signed [`SAMP_W-1:0] voiceSamples [`NUM_VOICES];

	// One control bundle per voice
	voiceCtrlIf voiceCtrl [`NUM_VOICES] ();

	// ====================
	// Command side
	// ====================
	noteDispatcher dispatcher (
		.MAX10_CLK2_50 (MAX10_CLK2_50),
		.arstN         (arstN),
		.cmdValid      (cmdValid),
		.cmd           (cmdWord),
		.voiceCtrl     (voiceCtrl),
		.masterLevel   (masterLevel)
	);

	// ====================
	// Voices
	// ====================
	for (genvar v = 0; v < `NUM_VOICES; v++) begin : gVoice
		oscVoice voice (
			.MAX10_CLK2_50 (MAX10_CLK2_50),
			.arstN         (arstN),
			.ctrl          (voiceCtrl[v]),
			.sampleTick    (sampleTick),
			.sample        (voiceSamples[v])
		);
	end

	// Output two cycles after each tick
	voiceMixer mixer (
		.MAX10_CLK2_50 (MAX10_CLK2_50),
		.arstN         (arstN),
		.sampleTick    (sampleTick),
		.voiceSamples  (voiceSamples),
		.masterLevel   (masterLevel),
		.sampleOut     (sampleOut),
		.sampleValid   (sampleValid)
	);

endmodule

//--- voiceMixer.sv
`include "synth_settings.svh"

module voiceMixer (
	input  logic                       MAX10_CLK2_50,
	input  logic                       arstN,
	input  logic                       sampleTick,
	input  logic signed [`SAMP_W-1:0]  voiceSamples [`NUM_VOICES],
	input  logic [`LEVEL_W-1:0]        masterLevel,
	output logic signed [`SAMP_W-1:0]  sampleOut,
	output logic                       sampleValid
);
	// Headroom for the sum of all voices
	localparam int SUM_W = `SAMP_W + $clog2(`NUM_VOICES);

	logic                           tickD1;
	logic signed [SUM_W-1:0]        voiceSum;
	logic signed [SUM_W+`LEVEL_W:0] product;

	// ====================
	// Sum and scale
	// ====================
	always_comb begin
		voiceSum = '0;
		for (int i = 0; i < `NUM_VOICES; i++) begin
			voiceSum += voiceSamples[i];
		end
		// Level is unsigned, zero extend before the signed multiply
		product = voiceSum * $signed({1'b0, masterLevel});
	end

	// Tick delayed to line up with the voice samples
	always_ff @(posedge MAX10_CLK2_50 or negedge arstN) begin
		if (!arstN) begin
			tickD1 <= 1'b0;
			sampleValid <= 1'b0;
		end else begin
			tickD1 <= sampleTick;
			sampleValid <= tickD1;
		end
	end

	// Arithmetic shift, low 16 bits kept
	// Full scale sum at level 255 still fits
	always_ff @(posedge MAX10_CLK2_50) begin
		if (tickD1) begin
			sampleOut <= product[`MIX_SHIFT +: `SAMP_W];
		end
	end

	// Pipeline needs ticks at least 3 cycles apart
	assert property (@(posedge MAX10_CLK2_50) disable iff (!arstN)
		sampleTick |=> !sampleTick [*2]);

endmodule

//--- oscVoice.sv
`include "synth_settings.svh"

module oscVoice (
	input  logic                       MAX10_CLK2_50,
	input  logic                       arstN,
	voiceCtrlIf.voice                  ctrl,
	input  logic                       sampleTick,
	output logic signed [`SAMP_W-1:0]  sample
);
	import synthPkg::*;

	logic [`PHASE_W-1:0]       phase;
	logic [`PHASE_W-1:0]       phaseNext;
	logic [`SAMP_W-1:0]        top;
	logic [`SAMP_W-2:0]        fold;
	logic signed [`SAMP_W-1:0] shaped;

	// ====================
	// Phase accumulator
	// ====================

	// A restart on a tick holds the phase at 0 for that tick
	assign phaseNext = ctrl.restart ? '0 : phase + ctrl.phaseInc;

	always_ff @(posedge MAX10_CLK2_50 or negedge arstN) begin
		if (!arstN) begin
			phase <= '0;
		end else if (ctrl.restart || sampleTick) begin
			phase <= phaseNext;
		end
	end

	// ====================
	// Waveform shaper
	// ====================

	// Top bits of the advanced phase
	assign top = phaseNext[`PHASE_W-1 -: `SAMP_W];

	// Second half of the cycle runs back down
	assign fold = top[`SAMP_W-1] ? ~top[`SAMP_W-2:0] : top[`SAMP_W-2:0];

	always_comb begin
		if (!ctrl.gate) begin
			shaped = '0;
		end else begin
			case (ctrl.wave)
				waveSaw: shaped = $signed(top);
				// Full scale, positive in the first half
				waveSquare: shaped = top[`SAMP_W-1] ?
					$signed({1'b1, {(`SAMP_W-1){1'b0}}}) :
					$signed({1'b0, {(`SAMP_W-1){1'b1}}});
				// Doubled fold, offset to signed range
				waveTri: shaped = $signed({~fold[`SAMP_W-2], fold[`SAMP_W-3:0], 1'b0});
				default: shaped = '0;
			endcase
		end
	end

	// Sample register, valid the cycle after the tick
	always_ff @(posedge MAX10_CLK2_50) begin
		if (sampleTick) begin
			sample <= shaped;
		end
	end

	// Phase is cleared right after restart, tick or not
	assert property (@(posedge MAX10_CLK2_50) disable iff (!arstN)
		ctrl.restart |=> (phase == '0));

endmodule

//--- noteDispatcher.sv
`include "synth_settings.svh"

module noteDispatcher (
	input  logic                  MAX10_CLK2_50,
	input  logic                  arstN,
	input  logic                  cmdValid,
	input  synthPkg::synthCmd     cmd,
	voiceCtrlIf.dispatcher        voiceCtrl [`NUM_VOICES],
	output logic [`LEVEL_W-1:0]   masterLevel
);
	import synthPkg::*;

	// Highest playable note, 2 octaves plus 6 semitones
	localparam int NOTE_MAX = 30;
	localparam int VOICE_W = $clog2(`NUM_VOICES);

	logic                   noteWrite;
	logic                   levelWrite;
	logic [3:0]             semitone;
	logic [1:0]             octave;
	logic [`PHASE_W-1:0]    incLookup;
	logic [`NUM_VOICES-1:0] restartVec;

	// ====================
	// Command decode
	// ====================

	// Out of range notes are dropped
	assign noteWrite = cmdValid && !cmd.asNote.kind && (cmd.asNote.noteIdx <= NOTE_MAX);
	assign levelWrite = cmdValid && cmd.asLevel.kind;

	// Split note into octave and semitone
	always_comb begin
		if (cmd.asNote.noteIdx >= 5'd24) begin
			octave = 2'd2;
			semitone = 4'(cmd.asNote.noteIdx - 5'd24);
		end else if (cmd.asNote.noteIdx >= 5'd12) begin
			octave = 2'd1;
			semitone = 4'(cmd.asNote.noteIdx - 5'd12);
		end else begin
			octave = 2'd0;
			semitone = 4'(cmd.asNote.noteIdx);
		end
		// Each octave doubles the step
		incLookup = semitoneInc[semitone] << octave;
	end

	// ====================
	// Per voice state
	// ====================
	for (genvar v = 0; v < `NUM_VOICES; v++) begin : gVoice
		logic hit;

		assign hit = noteWrite && (cmd.asNote.voice == VOICE_W'(v));

		always_ff @(posedge MAX10_CLK2_50 or negedge arstN) begin
			if (!arstN) begin
				voiceCtrl[v].gate <= 1'b0;
				voiceCtrl[v].wave <= waveOff;
				voiceCtrl[v].phaseInc <= '0;
				voiceCtrl[v].restart <= 1'b0;
			end else begin
				// Note-on restarts the phase, note-off only drops the gate
				voiceCtrl[v].restart <= hit && cmd.asNote.gate;
				if (hit) begin
					voiceCtrl[v].gate <= cmd.asNote.gate;
					voiceCtrl[v].wave <= cmd.asNote.wave;
					voiceCtrl[v].phaseInc <= incLookup;
				end
			end
		end

		assign restartVec[v] = voiceCtrl[v].restart;
	end

	// Master level register
	always_ff @(posedge MAX10_CLK2_50 or negedge arstN) begin
		if (!arstN) begin
			masterLevel <= `LEVEL_W'(`LEVEL_RESET);
		end else if (levelWrite) begin
			masterLevel <= cmd.asLevel.level;
		end
	end

	// One command per cycle, so at most one voice restarts
	assert property (@(posedge MAX10_CLK2_50) disable iff (!arstN)
		$onehot0(restartVec));

endmodule

//--- voiceCtrlIf.sv
`include "synth_settings.svh"

interface voiceCtrlIf;
	import synthPkg::*;

	// Voice enable, level
	logic                gate;
	// Shape of the output, level
	waveSel              wave;
	// Phase step per sample tick, level
	logic [`PHASE_W-1:0] phaseInc;
	// One cycle pulse on note-on, clears the phase
	logic                restart;

	// Dispatcher owns all control
	modport dispatcher (
		output gate,
		output wave,
		output phaseInc,
		output restart
	);

	// Voice side
	modport voice (
		input gate,
		input wave,
		input phaseInc,
		input restart
	);

endinterface

//--- synthPkg.sv
`include "synth_settings.svh"

package synthPkg;

	// ====================
	// Waveform select
	// ====================
	typedef enum logic [1:0] {
		waveSaw    = 2'd0,
		waveSquare = 2'd1,
		waveTri    = 2'd2,
		waveOff    = 2'd3
	} waveSel;

	// ====================
	// Command word
	// ====================

	// Note command, kind bit low
	typedef struct packed {
		logic                            kind;
		logic [$clog2(`NUM_VOICES)-1:0] voice;
		logic                            gate;
		waveSel                          wave;
		logic                            spare;
		logic [`NOTE_W-1:0]              noteIdx;
	} noteCmd;

	// Master level command, kind bit high
	typedef struct packed {
		logic                kind;
		logic [2:0]          spare;
		logic [`LEVEL_W-1:0] level;
	} levelCmd;

	// Same 12 bits, decoded by bit 11
	typedef union packed {
		noteCmd  asNote;
		levelCmd asLevel;
	} synthCmd;

	// ====================
	// Pitch table
	// ====================

	// Increments of the lowest octave, equal tempered
	// Note 0 sits at 2^27, one half period every 16 ticks
	// Higher octaves shift these left by note div 12
	localparam logic [`PHASE_W-1:0] semitoneInc [12] = '{
		32'd134217728, 32'd142198729, 32'd150654306, 32'd159612677,
		32'd169103741, 32'd179159172, 32'd189812537, 32'd201099372,
		32'd213057362, 32'd225726414, 32'd239148804, 32'd253369332
	};

endpackage

//--- synth_settings.svh
`ifndef SYNTH_SETTINGS_SVH
`define SYNTH_SETTINGS_SVH

// ====================
// Voice structure
// ====================

// Number of oscillator voices
`define NUM_VOICES 4

// Phase accumulator width
`define PHASE_W 32

// ====================
// Data path widths
// ====================

// Voice and mixer sample width, signed
`define SAMP_W 16
// Master level, unsigned
`define LEVEL_W 8
// Note index covers notes 0 to 30
`define NOTE_W 5

// Right shift applied after the level multiply
`define MIX_SHIFT 10
// Master level after reset
`define LEVEL_RESET 32

`endif
